// File: list.f
n64advPkg.sv
n64advVideoDemux.sv
n64advColorChannel.sv
n64advOutputStage.sv
n64advApbRegs.sv
n64advTop.sv
tbN64adv.sv

// File: n64advApbRegs.sv
`timescale 1ns/1ps

module n64advApbRegs (
  input  logic                  VCLK_i,
  input  logic                  rstN_i,
  input  logic                  pSel_i,
  input  logic                  pEnable_i,
  input  logic                  pWrite_i,
  input  n64advPkg::apbAddr_t   pAddr_i,
  input  n64advPkg::apbData_t   pWData_i,
  input  logic                  frameTick_i,
  output n64advPkg::apbData_t   pRData_o,
  output logic                  pReady_o,
  output logic                  pSlvErr_o,
  output logic                  outEn_o,
  output logic                  rgsbEn_o,
  output logic                  slEn_o,
  output n64advPkg::slStr_t     slStr_o
);

  logic [n64advPkg::cfgW-1:0] cfgReg;
  n64advPkg::frameCnt_t frameCnt;

  logic access;
  logic selCfg;
  logic selStat;
  logic selId;
  logic mapped;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign access = pSel_i && pEnable_i;
  assign selCfg = (pAddr_i == n64advPkg::regCfgAddr);
  assign selStat = (pAddr_i == n64advPkg::regStatAddr);
  assign selId = (pAddr_i == n64advPkg::regIdAddr);
  assign mapped = selCfg || selStat || selId;

  // No wait states
  assign pReady_o = 1'b1;
  assign pSlvErr_o = access && !mapped;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge rstN_i) begin
    if (!rstN_i) begin
      cfgReg <= n64advPkg::cfgResetValue[n64advPkg::cfgW-1:0];
      frameCnt <= '0;
    end else begin
      // Status and ID ignore writes
      if (access && pWrite_i && selCfg) begin
        cfgReg <= pWData_i[n64advPkg::cfgW-1:0];
      end
      // Counter wraps at full scale
      if (frameTick_i) begin
        frameCnt <= frameCnt + 1'b1;
      end
    end
  end

  // Read mux, fields zero extended and unmapped reads as zero
  always_comb begin
    pRData_o = '0;
    if (selCfg) begin
      pRData_o[n64advPkg::cfgW-1:0] = cfgReg;
    end else if (selStat) begin
      pRData_o[n64advPkg::frameCntW-1:0] = frameCnt;
    end else if (selId) begin
      pRData_o[n64advPkg::fwIdW-1:0] = n64advPkg::fwId;
    end
  end

  // Config fields to the video path
  assign outEn_o = cfgReg[n64advPkg::cfgBitOutEn];
  assign rgsbEn_o = cfgReg[n64advPkg::cfgBitRgsbEn];
  assign slEn_o = cfgReg[n64advPkg::cfgBitSlEn];
  assign slStr_o = cfgReg[n64advPkg::cfgSlStrLsb +: 2];

  apbEnableInSel: assert property (@(posedge VCLK_i) disable iff (!rstN_i)
    pEnable_i |-> pSel_i)
    else $error("APB pEnable without pSel");

endmodule

// File: n64advColorChannel.sv
`timescale 1ns/1ps

module n64advColorChannel (
  input  logic                  VCLK_i,
  input  logic                  rstN_i,
  input  logic                  valid_i,
  input  n64advPkg::vdIn_t      color_i,
  input  logic                  oddLine_i,
  input  logic                  csyncN_i,
  input  logic                  slEn_i,
  input  n64advPkg::slStr_t     slStr_i,
  output logic                  valid_o,
  output n64advPkg::colorOut_t  color_o,
  output logic                  csyncN_o
);

  n64advPkg::colorOut_t widened;
  n64advPkg::colorOut_t dimmed;
  // Product of 8 bit colour and 2 bit gain
  logic [n64advPkg::colorOutW+1:0] scaled;
  logic [1:0] keepQuarters;

  // MSB repeated into the new LSB so full scale maps to 0xFF
  assign widened = {color_i, color_i[n64advPkg::colorInW-1]};

  // Strength 0 keeps three quarters, strength 3 blanks the line
  assign keepQuarters = 2'd3 - slStr_i;
  assign scaled = {2'b00, widened} * {8'd0, keepQuarters};

  // Only odd lines get dimmed
  assign dimmed = (slEn_i && oddLine_i) ?
                  scaled[n64advPkg::colorOutW+1:2] : widened;

  always_ff @(posedge VCLK_i or negedge rstN_i) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
      csyncN_o <= 1'b1;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        csyncN_o <= csyncN_i;
      end
    end
  end

  // Colour holds between pixels
  always_ff @(posedge VCLK_i) begin
    if (valid_i) begin
      color_o <= dimmed;
    end
  end

  validDelay: assert property (@(posedge VCLK_i) disable iff (!rstN_i)
    valid_o == $past(valid_i))
    else $error("channel valid_o is not valid_i delayed by one cycle");

endmodule

// File: n64advOutputStage.sv
`timescale 1ns/1ps

module n64advOutputStage (
  input  logic                  VCLK_i,
  input  logic                  rstN_i,
  input  logic [2:0]            chValid_i,
  input  n64advPkg::colorOut_t  chR_i,
  input  n64advPkg::colorOut_t  chG_i,
  input  n64advPkg::colorOut_t  chB_i,
  input  logic                  chCsyncN_i,
  input  logic                  outEn_i,
  input  logic                  rgsbEn_i,
  output n64advPkg::pixelOut_t  vd_o,
  output logic                  nCSYNC_o
);

  logic pixIn;
  n64advPkg::colorOut_t greenOut;
  n64advPkg::pixelOut_t pixWord;

  // Channels run in lockstep
  assign pixIn = &chValid_i;

  // RGsB puts sync on green, so green goes black during sync
  assign greenOut = (rgsbEn_i && !chCsyncN_i) ? '0 : chG_i;
  assign pixWord = {chR_i, greenOut, chB_i};

  ////////////////////////////////////////
  // DAC output register
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge rstN_i) begin
    if (!rstN_i) begin
      vd_o <= '0;
      nCSYNC_o <= 1'b1;
    end else begin
      if (pixIn) begin
        nCSYNC_o <= chCsyncN_i;
      end
      // Disabled output stays black
      if (!outEn_i) begin
        vd_o <= '0;
      end else if (pixIn) begin
        vd_o <= pixWord;
      end
    end
  end

  // Red, green and blue channels come from separate instances
  chValidAligned: assert property (@(posedge VCLK_i) disable iff (!rstN_i)
    (&chValid_i) == (|chValid_i))
    else $error("colour channels out of step");

endmodule

// File: n64advPkg.sv
package n64advPkg;

  ////////////////////////////////////////
  // Video widths and word types
  ////////////////////////////////////////

  // Console VD bus carries 7 bit colours
  localparam int colorInW = 7;
  // DAC side gets 8 bits per colour
  localparam int colorOutW = 8;

  typedef logic [colorInW-1:0] vdIn_t;
  typedef logic [colorOutW-1:0] colorOut_t;
  // Red in the high byte, then green, then blue
  typedef logic [3*colorOutW-1:0] pixelOut_t;

  // Scanline strength code
  typedef logic [1:0] slStr_t;

  localparam int frameCntW = 16;
  typedef logic [frameCntW-1:0] frameCnt_t;

  // Word expected next on the VD bus
  typedef enum logic [1:0] {
    waitSync,
    wordR,
    wordG,
    wordB
  } demuxState_t;

  // Sync word bit positions, all active low
  localparam int syncBitV = 3;
  localparam int syncBitClamp = 2;
  localparam int syncBitH = 1;
  localparam int syncBitC = 0;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  typedef logic [3:0] apbAddr_t;
  typedef logic [31:0] apbData_t;

  localparam apbAddr_t regCfgAddr = 4'h0;
  localparam apbAddr_t regStatAddr = 4'h4;
  localparam apbAddr_t regIdAddr = 4'h8;

  // Configuration field layout
  localparam int cfgBitOutEn = 0;
  localparam int cfgBitRgsbEn = 1;
  localparam int cfgBitSlEn = 2;
  localparam int cfgSlStrLsb = 3;
  localparam int cfgW = 5;

  // Output on, everything else off
  localparam apbData_t cfgResetValue = 32'h0000_0001;

  // Main version 1, sub version 60
  localparam int fwIdW = 12;
  localparam logic [fwIdW-1:0] fwId = {4'd1, 8'd60};

endpackage

// File: n64advTop.sv
`timescale 1ns/1ps

module n64advTop (
  input  logic                  VCLK_i,
  input  logic                  rstN_i,
  input  logic                  nVDSYNC_i,
  input  n64advPkg::vdIn_t      vd_i,
  input  logic                  pSel_i,
  input  logic                  pEnable_i,
  input  logic                  pWrite_i,
  input  n64advPkg::apbAddr_t   pAddr_i,
  input  n64advPkg::apbData_t   pWData_i,
  output n64advPkg::pixelOut_t  vd_o,
  output logic                  nCSYNC_o,
  output n64advPkg::apbData_t   pRData_o,
  output logic                  pReady_o,
  output logic                  pSlvErr_o
);

  // Demux to channels
  logic pixValid;
  n64advPkg::vdIn_t pixR;
  n64advPkg::vdIn_t pixG;
  n64advPkg::vdIn_t pixB;
  logic pixCsyncN;
  logic pixOddLine;
  logic frameTick;

  // Register fields
  logic outEn;
  logic rgsbEn;
  logic slEn;
  n64advPkg::slStr_t slStr;

  // Channels to output stage
  logic [2:0] chValid;
  logic [2:0] chCsyncN;
  n64advPkg::colorOut_t chColor [3];

  n64advVideoDemux demux0 (
    .VCLK_i(VCLK_i),
    .rstN_i(rstN_i),
    .nVDSYNC_i(nVDSYNC_i),
    .vd_i(vd_i),
    .pixValid_o(pixValid),
    .pixR_o(pixR),
    .pixG_o(pixG),
    .pixB_o(pixB),
    .pixCsyncN_o(pixCsyncN),
    .pixOddLine_o(pixOddLine),
    .frameTick_o(frameTick)
  );

  ////////////////////////////////////////
  // Colour channels, 0 red, 1 green, 2 blue
  ////////////////////////////////////////

  for (genvar i = 0; i < 3; i++) begin : genChan
    n64advColorChannel chan0 (
      .VCLK_i(VCLK_i),
      .rstN_i(rstN_i),
      .valid_i(pixValid),
      .color_i(i == 0 ? pixR : (i == 1 ? pixG : pixB)),
      .oddLine_i(pixOddLine),
      .csyncN_i(pixCsyncN),
      .slEn_i(slEn),
      .slStr_i(slStr),
      .valid_o(chValid[i]),
      .color_o(chColor[i]),
      .csyncN_o(chCsyncN[i])
    );
  end

  // Sync taken from the green channel, which carries it in RGsB
  n64advOutputStage outStage0 (
    .VCLK_i(VCLK_i),
    .rstN_i(rstN_i),
    .chValid_i(chValid),
    .chR_i(chColor[0]),
    .chG_i(chColor[1]),
    .chB_i(chColor[2]),
    .chCsyncN_i(chCsyncN[1]),
    .outEn_i(outEn),
    .rgsbEn_i(rgsbEn),
    .vd_o(vd_o),
    .nCSYNC_o(nCSYNC_o)
  );

  n64advApbRegs regs0 (
    .VCLK_i(VCLK_i),
    .rstN_i(rstN_i),
    .pSel_i(pSel_i),
    .pEnable_i(pEnable_i),
    .pWrite_i(pWrite_i),
    .pAddr_i(pAddr_i),
    .pWData_i(pWData_i),
    .frameTick_i(frameTick),
    .pRData_o(pRData_o),
    .pReady_o(pReady_o),
    .pSlvErr_o(pSlvErr_o),
    .outEn_o(outEn),
    .rgsbEn_o(rgsbEn),
    .slEn_o(slEn),
    .slStr_o(slStr)
  );

endmodule

// File: n64advVideoDemux.sv
`timescale 1ns/1ps

module n64advVideoDemux (
  input  logic               VCLK_i,
  input  logic               rstN_i,
  input  logic               nVDSYNC_i,
  input  n64advPkg::vdIn_t   vd_i,
  output logic               pixValid_o,
  output n64advPkg::vdIn_t   pixR_o,
  output n64advPkg::vdIn_t   pixG_o,
  output n64advPkg::vdIn_t   pixB_o,
  output logic               pixCsyncN_o,
  output logic               pixOddLine_o,
  output logic               frameTick_o
);

  n64advPkg::demuxState_t state;

  // Registered VD bus word
  logic nVDSYNCReg;
  n64advPkg::vdIn_t vdReg;

  // Partial pixel storage
  n64advPkg::vdIn_t redLatch;
  n64advPkg::vdIn_t greenLatch;
  logic csyncLatch;

  // Sync history for edge detection
  logic prevHsyncN;
  logic prevVsyncN;
  logic oddLine;

  logic isSync;
  logic hFall;
  logic vFall;

  // Sample the bus once per VCLK
  always_ff @(posedge VCLK_i or negedge rstN_i) begin
    if (!rstN_i) begin
      nVDSYNCReg <= 1'b1;
    end else begin
      nVDSYNCReg <= nVDSYNC_i;
    end
  end

  always_ff @(posedge VCLK_i) begin
    vdReg <= vd_i;
  end

  assign isSync = !nVDSYNCReg;
  // Falling edges only count between two sync words
  assign hFall = isSync && prevHsyncN && !vdReg[n64advPkg::syncBitH];
  assign vFall = isSync && prevVsyncN && !vdReg[n64advPkg::syncBitV];

  ////////////////////////////////////////
  // Line parity and frame tick
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge rstN_i) begin
    if (!rstN_i) begin
      prevHsyncN <= 1'b1;
      prevVsyncN <= 1'b1;
      oddLine <= 1'b0;
      frameTick_o <= 1'b0;
    end else begin
      frameTick_o <= vFall;
      if (isSync) begin
        prevHsyncN <= vdReg[n64advPkg::syncBitH];
        prevVsyncN <= vdReg[n64advPkg::syncBitV];
      end
      // New frame starts on an even line
      if (vFall) begin
        oddLine <= 1'b0;
      end else if (hFall) begin
        oddLine <= !oddLine;
      end
    end
  end

  ////////////////////////////////////////
  // Word sequencing
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state <= n64advPkg::waitSync;
      pixValid_o <= 1'b0;
    end else begin
      pixValid_o <= 1'b0;
      // Sync word always restarts the pixel
      if (isSync) begin
        state <= n64advPkg::wordR;
      end else begin
        case (state)
          n64advPkg::wordR: state <= n64advPkg::wordG;
          n64advPkg::wordG: state <= n64advPkg::wordB;
          n64advPkg::wordB: begin
            state <= n64advPkg::waitSync;
            pixValid_o <= 1'b1;
          end
          // Stray colour words while waiting are dropped
          default: state <= n64advPkg::waitSync;
        endcase
      end
    end
  end

  // Pixel payload, qualified by pixValid_o downstream
  always_ff @(posedge VCLK_i) begin
    if (isSync) begin
      csyncLatch <= vdReg[n64advPkg::syncBitC];
    end
    if (!isSync && state == n64advPkg::wordR) begin
      redLatch <= vdReg;
    end
    if (!isSync && state == n64advPkg::wordG) begin
      greenLatch <= vdReg;
    end
    if (!isSync && state == n64advPkg::wordB) begin
      pixR_o <= redLatch;
      pixG_o <= greenLatch;
      pixB_o <= vdReg;
      pixCsyncN_o <= csyncLatch;
      pixOddLine_o <= oddLine;
    end
  end

  // At least four words make up one pixel
  pixValidSingle: assert property (@(posedge VCLK_i) disable iff (!rstN_i)
    pixValid_o |=> !pixValid_o)
    else $error("demux pixValid high on consecutive cycles");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the N64 video path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbN64adv \
  -f list.f -o simN64adv

./obj_dir/simN64adv | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: tbN64adv.sv
`timescale 1ns/1ps

module tbN64adv;

  ////////////////////////////////////////
  // Run length and cycle limit
  ////////////////////////////////////////

  localparam int numRandPix = 200;
  // Four strengths of one vsync pixel plus three lines of eight
  localparam int numDimPix = 4 * (1 + 3 * 8);
  localparam int numRgsbPix = 60;
  localparam int numFrames = 5;
  localparam int totalPix = numRandPix + numDimPix + numRgsbPix + 2 * numFrames;
  // Setup, access and release per transfer
  localparam int apbXfers = 14;
  localparam int apbCycles = 3 * apbXfers;
  localparam int cycleLimit = totalPix * 4 + apbCycles + 200;

  logic vclk;
  logic rstN;
  logic nVdSync;
  n64advPkg::vdIn_t vdIn;
  logic pSel;
  logic pEnable;
  logic pWrite;
  n64advPkg::apbAddr_t pAddr;
  n64advPkg::apbData_t pWData;
  n64advPkg::pixelOut_t vdOut;
  logic nCsync;
  n64advPkg::apbData_t pRData;
  logic pReady;
  logic pSlvErr;

  int cycleCnt;
  int errCnt;
  int testPass;
  int testFail;

  // Console side model of sync history
  logic prevHsyncN;
  logic prevVsyncN;
  logic oddModel;
  int frameModel;
  // Last configuration written
  n64advPkg::apbData_t cfgModel;

  // Pixels in flight and the cycle each one reaches vd_o
  n64advPkg::pixelOut_t expPixQ[$];
  logic expSyncQ[$];
  int dueQ[$];

  n64advTop dut0 (
    .VCLK_i(vclk),
    .rstN_i(rstN),
    .nVDSYNC_i(nVdSync),
    .vd_i(vdIn),
    .pSel_i(pSel),
    .pEnable_i(pEnable),
    .pWrite_i(pWrite),
    .pAddr_i(pAddr),
    .pWData_i(pWData),
    .vd_o(vdOut),
    .nCSYNC_o(nCsync),
    .pRData_o(pRData),
    .pReady_o(pReady),
    .pSlvErr_o(pSlvErr)
  );

  initial begin
    vclk = 1'b0;
  end

  // 8 ns VCLK
  always #4 vclk = ~vclk;

  // Cycle count that also bounds the run
  always @(posedge vclk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Expected pixel
  ////////////////////////////////////////

  function automatic n64advPkg::pixelOut_t n64advRef(
    input n64advPkg::vdIn_t r,
    input n64advPkg::vdIn_t g,
    input n64advPkg::vdIn_t b,
    input logic oddLine,
    input logic csyncN,
    input n64advPkg::apbData_t cfg
  );
    n64advPkg::vdIn_t src [3];
    int chan [3];
    int gain;
    logic dim;
    src[0] = r;
    src[1] = g;
    src[2] = b;
    gain = 3 - int'(cfg[n64advPkg::cfgSlStrLsb +: 2]);
    dim = cfg[n64advPkg::cfgBitSlEn] && oddLine;
    for (int i = 0; i < 3; i++) begin
      // Top bit repeated below the 7 bit colour
      chan[i] = int'({src[i], src[i][n64advPkg::colorInW-1]});
      // Quarter steps with two bits dropped
      if (dim) begin
        chan[i] = (chan[i] * gain) / 4;
      end
    end
    // Green carries sync in RGsB
    if (cfg[n64advPkg::cfgBitRgsbEn] && !csyncN) begin
      chan[1] = 0;
    end
    if (!cfg[n64advPkg::cfgBitOutEn]) begin
      return '0;
    end
    return {chan[0][7:0], chan[1][7:0], chan[2][7:0]};
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkPixel(input string name, input n64advPkg::pixelOut_t got,
                            input n64advPkg::pixelOut_t exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic checkSync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic checkRead(input string name, input n64advPkg::apbData_t got,
                           input n64advPkg::apbData_t exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  // vd_o and nCSYNC_o are stable at the falling edge
  always @(negedge vclk) begin
    if (dueQ.size() > 0 && dueQ[0] == cycleCnt) begin
      checkPixel("vd_o", vdOut, expPixQ.pop_front());
      checkSync("nCSYNC_o", nCsync, expSyncQ.pop_front());
      dueQ.delete(0);
    end
  end

  ////////////////////////////////////////
  // Console bus
  ////////////////////////////////////////

  task automatic driveWord(input logic nSync, input n64advPkg::vdIn_t word);
    @(posedge vclk);
    #1;
    nVdSync = nSync;
    vdIn = word;
  endtask

  // One sync word followed by red, green and blue
  task automatic sendPixel(input logic vN, input logic hN, input logic cN);
    n64advPkg::vdIn_t r;
    n64advPkg::vdIn_t g;
    n64advPkg::vdIn_t b;
    n64advPkg::vdIn_t syncWord;
    r = n64advPkg::vdIn_t'($urandom_range(0, 127));
    g = n64advPkg::vdIn_t'($urandom_range(0, 127));
    b = n64advPkg::vdIn_t'($urandom_range(0, 127));
    // Clamp inactive and unused bits high
    syncWord = {3'b111, vN, 1'b1, hN, cN};
    // Vsync fall starts an even line and hsync fall flips parity
    if (prevVsyncN && !vN) begin
      oddModel = 1'b0;
      frameModel++;
    end else if (prevHsyncN && !hN) begin
      oddModel = !oddModel;
    end
    prevVsyncN = vN;
    prevHsyncN = hN;
    driveWord(1'b0, syncWord);
    driveWord(1'b1, r);
    driveWord(1'b1, g);
    driveWord(1'b1, b);
    expPixQ.push_back(n64advRef(r, g, b, oddModel, cN, cfgModel));
    expSyncQ.push_back(cN);
    // Blue sampled at the next edge plus three stages
    dueQ.push_back(cycleCnt + 4);
  endtask

  task automatic drainPipe();
    while (dueQ.size() != 0) begin
      @(posedge vclk);
    end
    repeat (2) @(posedge vclk);
  endtask

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apbWrite(input n64advPkg::apbAddr_t addr, input n64advPkg::apbData_t data,
                          output logic err);
    @(posedge vclk);
    #1;
    pSel = 1'b1;
    pEnable = 1'b0;
    pWrite = 1'b1;
    pAddr = addr;
    pWData = data;
    @(posedge vclk);
    #1;
    pEnable = 1'b1;
    @(negedge vclk);
    // No wait states on this slave
    checkFlag("pReady_o", pReady, 1'b1);
    while (!pReady) begin
      @(negedge vclk);
    end
    err = pSlvErr;
    @(posedge vclk);
    #1;
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
  endtask

  task automatic apbRead(input n64advPkg::apbAddr_t addr, output n64advPkg::apbData_t data,
                         output logic err);
    @(posedge vclk);
    #1;
    pSel = 1'b1;
    pEnable = 1'b0;
    pWrite = 1'b0;
    pAddr = addr;
    @(posedge vclk);
    #1;
    pEnable = 1'b1;
    @(negedge vclk);
    // No wait states on this slave
    checkFlag("pReady_o", pReady, 1'b1);
    while (!pReady) begin
      @(negedge vclk);
    end
    data = pRData;
    err = pSlvErr;
    @(posedge vclk);
    #1;
    pSel = 1'b0;
    pEnable = 1'b0;
  endtask

  // Config changes only between bursts
  task automatic writeCfg(input n64advPkg::apbData_t data);
    logic err;
    drainPipe();
    apbWrite(n64advPkg::regCfgAddr, data, err);
    checkFlag("pSlvErr_o", err, 1'b0);
    cfgModel = data;
  endtask

  task automatic endTest(input string name, input int errAtStart);
    if (errCnt == errAtStart) begin
      testPass++;
      $display("%s: ok", name);
    end else begin
      testFail++;
      $display("%s: %0d errors", name, errCnt - errAtStart);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    n64advPkg::apbData_t rd;
    logic err;
    int errStart;
    void'($urandom(32'h881673b4));
    rstN = 1'b0;
    nVdSync = 1'b1;
    vdIn = '0;
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
    pAddr = '0;
    pWData = '0;
    cycleCnt = 0;
    errCnt = 0;
    testPass = 0;
    testFail = 0;
    prevHsyncN = 1'b1;
    prevVsyncN = 1'b1;
    oddModel = 1'b0;
    frameModel = 0;
    cfgModel = n64advPkg::cfgResetValue;
    repeat (3) @(posedge vclk);
    #1;
    rstN = 1'b1;

    // Reset values and ID version 1.60
    errStart = errCnt;
    apbRead(n64advPkg::regCfgAddr, rd, err);
    checkRead("cfg", rd, 32'h0000_0001);
    apbRead(n64advPkg::regStatAddr, rd, err);
    checkRead("status", rd, 32'h0000_0000);
    apbRead(n64advPkg::regIdAddr, rd, err);
    checkRead("id", rd, 32'h0000_013c);
    checkSync("nCSYNC_o", nCsync, 1'b1);
    checkPixel("vd_o", vdOut, '0);
    endTest("reset and ID", errStart);

    // Widening only
    errStart = errCnt;
    writeCfg(32'h0000_0001);
    for (int i = 0; i < numRandPix; i++) begin
      sendPixel(1'b1, 1'b1, 1'($urandom_range(0, 1)));
    end
    drainPipe();
    endTest("plain widening", errStart);

    // Each strength gets a frame of three lines
    errStart = errCnt;
    for (int str = 0; str < 4; str++) begin
      writeCfg(32'h0000_0005 | (str << n64advPkg::cfgSlStrLsb));
      sendPixel(1'b0, 1'b1, 1'b1);
      for (int line = 0; line < 3; line++) begin
        for (int px = 0; px < 8; px++) begin
          sendPixel(1'b1, px != 0, px != 0);
        end
      end
    end
    drainPipe();
    endTest("scanline dimming", errStart);

    // Sync on green and then output off
    errStart = errCnt;
    writeCfg(32'h0000_0003);
    for (int i = 0; i < 40; i++) begin
      sendPixel(1'b1, 1'b1, 1'($urandom_range(0, 1)));
    end
    writeCfg(32'h0000_0000);
    for (int i = 0; i < numRgsbPix - 40; i++) begin
      sendPixel(1'b1, 1'b1, 1'($urandom_range(0, 1)));
    end
    drainPipe();
    checkPixel("vd_o", vdOut, '0);
    endTest("RGsB and output enable", errStart);

    // Counter holds every vsync fall since reset
    errStart = errCnt;
    for (int i = 0; i < numFrames; i++) begin
      sendPixel(1'b0, 1'b1, 1'b1);
      sendPixel(1'b1, 1'b1, 1'b1);
    end
    drainPipe();
    apbRead(n64advPkg::regStatAddr, rd, err);
    checkRead("status", rd, n64advPkg::apbData_t'(frameModel));
    endTest("frame count", errStart);

    // Unmapped address 12
    errStart = errCnt;
    apbWrite(4'hc, 32'h0000_001f, err);
    checkFlag("pSlvErr_o", err, 1'b1);
    apbRead(4'hc, rd, err);
    checkFlag("pSlvErr_o", err, 1'b1);
    checkRead("unmapped", rd, 32'h0000_0000);
    apbRead(n64advPkg::regCfgAddr, rd, err);
    checkRead("cfg", rd, cfgModel);
    endTest("APB errors", errStart);

    $display("tests passed %0d failed %0d", testPass, testFail);
    if (errCnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
